// File: compile.f
+incdir+rtl
rtl/pmp_pkg.sv
rtl/pmp_entry_if.sv
rtl/pmp_csr_regs.sv
rtl/pmp_addr_matcher.sv
rtl/pmp_priority_check.sv
rtl/pmp_checker.sv
verif/pmp_checker_asserts.sv
verif/pmp_result_check.sv
verif/pmp_checker_tb.sv

// File: rtl/pmp_addr_matcher.sv
// ----------------------------------------------------------
// combinational address match for one PMP entry
// phys_addr is a word address compared directly with pmpaddr
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_addr_matcher (
  input  logic [31:0]  phys_addr, // word address under check
  pmp_entry_if.match   entry,     // cfg and bounds of this entry
  output logic         match      // entry covers phys_addr
);

  // smallest trailing-ones count that still forms a region
  localparam int KMIN       = (`PMP_GRAIN == 0) ? 0 : `PMP_GRAIN - 1;
  localparam int NAPOT_SETS = 31 - KMIN; // sizes KMIN .. 30 trailing ones

  logic [NAPOT_SETS+1:0] napot_hit; // one per region size, plus two all-ones
  logic                  tor_hit;

  // region with k trailing ones in pmpaddr covers 2^(k+1) words
  for (genvar i = 0; i < NAPOT_SETS; i++) begin : g_napot
    localparam int          K        = i + KMIN;
    localparam logic [31:0] LOW_ONES = (32'h1 << K) - 32'h1; // k ones then a zero

    assign napot_hit[i] = (entry.addr[K:0] == LOW_ONES[K:0]) &&
                          (phys_addr[31:K+1] == entry.addr[31:K+1]);
  end

  // whole address space
  assign napot_hit[NAPOT_SETS]   = (entry.addr == 32'h7fff_ffff);
  assign napot_hit[NAPOT_SETS+1] = (entry.addr == 32'hffff_ffff);

  // empty or inverted range never matches
  assign tor_hit = (entry.addr_before < entry.addr) &&
                   (phys_addr >= entry.addr_before) &&
                   (phys_addr < entry.addr);

  always_comb begin
    match = 1'b0;
    if (entry.active) begin
      case (entry.cfg.a)
        pmp_pkg::TOR:   match = tor_hit;
        pmp_pkg::NA4:   match = (phys_addr == entry.addr); // exactly one word
        pmp_pkg::NAPOT: match = |napot_hit;
        default:        match = 1'b0;
      endcase
    end
  end

endmodule

// File: rtl/pmp_checker.sv
// ----------------------------------------------------------
// PMP checker top, CSR write port in, one check per cycle
// result 1 cycle after chk_valid, no back-pressure
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_checker (
  input  logic                 clk,
  input  logic                 rst,
  // CSR write port
  input  logic                 csr_we,
  input  logic                 csr_sel_cfg, // 1: pmpcfg word, 0: pmpaddr
  input  logic [2:0]           csr_index,
  input  logic [31:0]          csr_wdata,
  // check port
  input  logic                 chk_valid,
  input  logic [31:0]          chk_addr,    // word address
  input  pmp_pkg::pmp_access_e chk_access,
  input  logic                 chk_priv_m,
  // result
  output logic                 res_valid,
  output logic                 res_fault,
  output logic [2:0]           res_entry,
  output logic                 res_hit
);

  pmp_entry_if entry_if [`PMP_ENTRIES] (); // one per entry

  logic [`PMP_ENTRIES-1:0] match_vec;       // bit per matcher

  pmp_csr_regs pmp_csr_regs_i (
    .clk         (clk),
    .rst         (rst),
    .csr_we      (csr_we),
    .csr_sel_cfg (csr_sel_cfg),
    .csr_index   (csr_index),
    .csr_wdata   (csr_wdata),
    .entries     (entry_if)
  );

  for (genvar g = 0; g < `PMP_ENTRIES; g++) begin : g_match
    pmp_addr_matcher pmp_addr_matcher_i (
      .phys_addr (chk_addr),
      .entry     (entry_if[g]),
      .match     (match_vec[g])
    );
  end

  pmp_priority_check pmp_priority_check_i (
    .clk        (clk),
    .rst        (rst),
    .chk_valid  (chk_valid),
    .chk_access (chk_access),
    .chk_priv_m (chk_priv_m),
    .match      (match_vec),
    .entries    (entry_if),
    .res_valid  (res_valid),
    .res_fault  (res_fault),
    .res_entry  (res_entry),
    .res_hit    (res_hit)
  );

endmodule

// File: rtl/pmp_csr_regs.sv
// ----------------------------------------------------------
// pmpcfg / pmpaddr storage, write only, no read back
// locked bytes and addresses ignore writes until reset
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_csr_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               csr_we,      // write strobe
  input  logic               csr_sel_cfg, // 1: cfg word, 0: address
  input  logic [2:0]         csr_index,   // cfg word number or entry number
  input  logic [31:0]        csr_wdata,
  pmp_entry_if.regs          entries [`PMP_ENTRIES]
);

  pmp_pkg::pmp_cfg_word_u wr_word;                   // write data split into bytes
  pmp_pkg::pmp_cfg_t      cfg_q  [`PMP_ENTRIES];     // cfg byte per entry
  logic [31:0]            addr_q [`PMP_ENTRIES];     // pmpaddr per entry
  logic                   cfg_wr  [`PMP_ENTRIES];    // cfg byte write enable
  logic                   addr_wr [`PMP_ENTRIES];    // address write enable

  assign wr_word.raw = csr_wdata;

  if (`PMP_ENTRIES % 4 != 0) begin : g_size_check
    $error("PMP_ENTRIES must be a multiple of 4");
  end

  for (genvar e = 0; e < `PMP_ENTRIES; e++) begin : g_entry

    // byte e % 4 of cfg word e / 4, dropped when locked
    assign cfg_wr[e]  = csr_we && csr_sel_cfg && (csr_index == 3'(e / 4)) && !cfg_q[e].l;
    assign addr_wr[e] = csr_we && !csr_sel_cfg && (csr_index == 3'(e)) && !cfg_q[e].l;

    always_ff @(posedge clk) begin
      if (rst) begin
        cfg_q[e] <= '0;                  // OFF and unlocked
      end else if (cfg_wr[e]) begin
        cfg_q[e] <= wr_word.bytes[e % 4];
      end
    end

    // addresses cleared too so TOR bounds start at zero
    always_ff @(posedge clk) begin
      if (rst) begin
        addr_q[e] <= '0;
      end else if (addr_wr[e]) begin
        addr_q[e] <= csr_wdata;
      end
    end

    assign entries[e].cfg    = cfg_q[e];
    assign entries[e].addr   = addr_q[e];
    assign entries[e].active = (cfg_q[e].a != pmp_pkg::OFF);

    if (e == 0) begin : g_first
      assign entries[e].addr_before = 32'd0; // TOR of entry 0 starts at 0
    end else begin : g_rest
      assign entries[e].addr_before = addr_q[e-1];
    end

  end

endmodule

// File: rtl/pmp_entry_if.sv
// ----------------------------------------------------------
// one PMP entry as seen by its matcher and the priority check
// addr_before is zero for entry 0
// ----------------------------------------------------------
`timescale 1ns/100ps

interface pmp_entry_if;

  pmp_pkg::pmp_cfg_t cfg;         // config byte of this entry
  logic [31:0]       addr;        // pmpaddr, word address
  logic [31:0]       addr_before; // pmpaddr of entry - 1, TOR lower bound
  logic              active;      // mode != OFF

  // register file side
  modport regs (
    output cfg,
    output addr,
    output addr_before,
    output active
  );

  // matcher and priority check side
  modport match (
    input cfg,
    input addr,
    input addr_before,
    input active
  );

endinterface

// File: rtl/pmp_pkg.sv
// ----------------------------------------------------------
// PMP types shared by RTL and testbench
// cfg byte layout follows the RISC-V pmpcfg format
// ----------------------------------------------------------
package pmp_pkg;

  // address matching mode, A field of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'd0, // entry disabled
    TOR   = 2'd1, // top of range, lower bound from previous entry
    NA4   = 2'd2, // single word
    NAPOT = 2'd3  // naturally aligned power of two
  } pmp_mode_e;

  // one entry configuration byte, msb first
  typedef struct packed {
    logic      l;    // lock, also enforces in machine mode
    logic [1:0] rsvd; // stored as written
    pmp_mode_e a;    // address mode
    logic      x;    // execute allowed
    logic      w;    // write allowed
    logic      r;    // read allowed
  } pmp_cfg_t;

  // a pmpcfg CSR word, raw or as four entry bytes
  typedef union packed {
    logic [31:0]        raw;   // as written on the CSR port
    pmp_cfg_t [3:0]     bytes; // bytes[0] is the lowest entry of the word
  } pmp_cfg_word_u;

  // kind of access being checked
  typedef enum logic [1:0] {
    READ  = 2'd0,
    WRITE = 2'd1,
    EXEC  = 2'd2
  } pmp_access_e;

endpackage

// File: rtl/pmp_priority_check.sv
// ----------------------------------------------------------
// lowest matching entry decides, result one cycle after check
// no hit: allowed in machine mode only
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_priority_check (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     chk_valid,  // check strobe
  input  pmp_pkg::pmp_access_e     chk_access, // read, write or exec
  input  logic                     chk_priv_m, // machine mode access
  input  logic [`PMP_ENTRIES-1:0]  match,      // per-entry match bits
  pmp_entry_if.match               entries [`PMP_ENTRIES],
  output logic                     res_valid,
  output logic                     res_fault,
  output logic [2:0]               res_entry,  // winning entry
  output logic                     res_hit     // some entry matched
);

  pmp_pkg::pmp_cfg_t cfg_vec [`PMP_ENTRIES]; // cfg bytes pulled off the interfaces
  pmp_pkg::pmp_cfg_t sel_cfg;                // cfg of winning entry
  logic [2:0]        sel_idx;
  logic              hit;
  logic              perm;                   // winner grants this access kind
  logic              fault;

  for (genvar g = 0; g < `PMP_ENTRIES; g++) begin : g_cfg
    assign cfg_vec[g] = entries[g].cfg;
  end

  always_comb begin
    hit     = 1'b0;
    sel_idx = '0;
    sel_cfg = '0;
    // scan down so the lowest index is written last
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        sel_idx = 3'(i);
        sel_cfg = cfg_vec[i];
      end
    end

    case (chk_access)
      pmp_pkg::READ:  perm = sel_cfg.r;
      pmp_pkg::WRITE: perm = sel_cfg.w;
      pmp_pkg::EXEC:  perm = sel_cfg.x;
      default:        perm = 1'b0; // unused encoding
    endcase

    if (!hit) begin
      fault = !chk_priv_m;         // default deny below machine mode
    end else if (chk_priv_m && !sel_cfg.l) begin
      fault = 1'b0;                // unlocked entries do not bind M mode
    end else begin
      fault = !perm;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res_fault <= 1'b0;
    end else begin
      res_valid <= chk_valid;
      res_fault <= chk_valid && fault; // only with a valid result
    end
  end

  // result payload, held between checks
  always_ff @(posedge clk) begin
    if (chk_valid) begin
      res_entry <= sel_idx;
      res_hit   <= hit;
    end
  end

endmodule

// File: rtl/pmp_settings.svh
// ----------------------------------------------------------
// build-time sizing for the PMP checker
// PMP_ENTRIES must be a multiple of 4 (one cfg word = 4 bytes)
// ----------------------------------------------------------
`ifndef PMP_SETTINGS_SVH
`define PMP_SETTINGS_SVH

// number of PMP entries, 8 fits the 3-bit csr_index and res_entry
`define PMP_ENTRIES 8

// NAPOT granularity exponent
// 0 allows the smallest NAPOT region (addr[0] == 0)
// G > 0 needs at least G-1 trailing ones in pmpaddr
`define PMP_GRAIN 0

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PMP checker testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
  --top-module pmp_checker_tb -Mdir obj_dir -o pmp_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pmp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

// File: verif/pmp_checker_asserts.sv
// ----------------------------------------------------------
// result strobe timing checks bound into pmp_checker
// fail_count is read by the testbench at the end
// ----------------------------------------------------------
`timescale 1ns/100ps

module pmp_checker_asserts (
  input logic clk,
  input logic rst,
  input logic chk_valid,
  input logic res_valid,
  input logic res_fault
);

  int fail_count = 0; // bumped by every failing assertion

  // exactly one cycle of latency with no extra results
  a_valid_follows: assert property (@(posedge clk) disable iff (rst) chk_valid |=> res_valid)
    else begin
      fail_count++;
      $error("res_valid missing one cycle after chk_valid");
    end

  a_no_stray_valid: assert property (@(posedge clk) disable iff (rst) !chk_valid |=> !res_valid)
    else begin
      fail_count++;
      $error("res_valid set without chk_valid a cycle before");
    end

  a_fault_needs_valid: assert property (@(posedge clk) res_fault |-> res_valid)
    else begin
      fail_count++;
      $error("res_fault set without res_valid");
    end

  // sync reset clears both on the next edge
  a_reset_idle: assert property (@(posedge clk) rst |=> (!res_valid && !res_fault))
    else begin
      fail_count++;
      $error("result strobes not low after reset edge");
    end

endmodule

bind pmp_checker pmp_checker_asserts asserts_i (
  .clk       (clk),
  .rst       (rst),
  .chk_valid (chk_valid),
  .res_valid (res_valid),
  .res_fault (res_fault)
);

// File: verif/pmp_checker_tb.sv
// ----------------------------------------------------------
// directed PMP checker tests followed by a random mix
// expects PMP_ENTRIES == 8 with checks done in pmp_result_check
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_checker_tb;

  localparam int NUM_RANDOM     = 300;              // random mix cycles
  localparam int DIRECTED_BOUND = 450;              // upper bound for tests 1 to 5
  localparam int MAX_CYCLES     = 6 * 8 + DIRECTED_BOUND + NUM_RANDOM + 50;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 csr_we;
  logic                 csr_sel_cfg;
  logic [2:0]           csr_index;
  logic [31:0]          csr_wdata;
  logic                 chk_valid;
  logic [31:0]          chk_addr;
  pmp_pkg::pmp_access_e chk_access;
  logic                 chk_priv_m;
  logic                 res_valid;
  logic                 res_fault;
  logic [2:0]           res_entry;
  logic                 res_hit;
  logic [3:0]           test_id;
  int                   err_total;
  logic                 summary_done;

  logic [31:0] lfsr_state = 32'hd017;
  logic [31:0] r_we, r_sel, r_idx, r_data, r_acc, r_addr, r_pm; // random mix draws
  logic [31:0] tor_pts [7] = '{32'h0ff, 32'h100, 32'h101, 32'h1ff, 32'h200, 32'h201, 32'h150};

  pmp_checker pmp_checker_i (
    .clk (clk), .rst (rst),
    .csr_we (csr_we), .csr_sel_cfg (csr_sel_cfg), .csr_index (csr_index), .csr_wdata (csr_wdata),
    .chk_valid (chk_valid), .chk_addr (chk_addr), .chk_access (chk_access),
    .chk_priv_m (chk_priv_m),
    .res_valid (res_valid), .res_fault (res_fault), .res_entry (res_entry), .res_hit (res_hit)
  );

  pmp_result_check result_check_i (
    .clk (clk), .rst (rst),
    .csr_we (csr_we), .csr_sel_cfg (csr_sel_cfg), .csr_index (csr_index), .csr_wdata (csr_wdata),
    .chk_valid (chk_valid), .chk_addr (chk_addr), .chk_access (chk_access),
    .chk_priv_m (chk_priv_m),
    .res_valid (res_valid), .res_fault (res_fault), .res_entry (res_entry), .res_hit (res_hit),
    .test_id (test_id), .err_total (err_total), .summary_done (summary_done)
  );

  initial begin
    forever #5 clk = ~clk; // 10 ns period
  end

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic pmp_pkg::pmp_cfg_t cfg_byte(input logic l, input pmp_pkg::pmp_mode_e a,
                                                 input logic [2:0] xwr);
    pmp_pkg::pmp_cfg_t c;
    c             = '0;
    c.l           = l;
    c.a           = a;
    {c.x, c.w, c.r} = xwr;
    return c;
  endfunction

  // b0 is the lowest entry of the word
  function automatic logic [31:0] cfg_word(input pmp_pkg::pmp_cfg_t b3, input pmp_pkg::pmp_cfg_t b2,
                                           input pmp_pkg::pmp_cfg_t b1, input pmp_pkg::pmp_cfg_t b0);
    pmp_pkg::pmp_cfg_word_u u;
    u.bytes[0] = b0;
    u.bytes[1] = b1;
    u.bytes[2] = b2;
    u.bytes[3] = b3;
    return u.raw;
  endfunction

  // one clock of stimulus where a write and a check may share the cycle
  task automatic drive(input logic we, input logic sel, input logic [2:0] idx,
                       input logic [31:0] data, input logic cv, input logic [31:0] addr,
                       input pmp_pkg::pmp_access_e acc, input logic pm);
    @(posedge clk);
    csr_we      <= we;
    csr_sel_cfg <= sel;
    csr_index   <= idx;
    csr_wdata   <= data;
    chk_valid   <= cv;
    chk_addr    <= addr;
    chk_access  <= acc;
    chk_priv_m  <= pm;
  endtask

  task automatic idle();
    drive(1'b0, 1'b0, 3'd0, 32'd0, 1'b0, 32'd0, pmp_pkg::READ, 1'b0);
  endtask

  task automatic write_cfg(input logic [2:0] idx, input logic [31:0] data);
    drive(1'b1, 1'b1, idx, data, 1'b0, 32'd0, pmp_pkg::READ, 1'b0);
  endtask

  task automatic write_addr(input logic [2:0] idx, input logic [31:0] data);
    drive(1'b1, 1'b0, idx, data, 1'b0, 32'd0, pmp_pkg::READ, 1'b0);
  endtask

  task automatic check(input logic [31:0] addr, input pmp_pkg::pmp_access_e acc, input logic pm);
    drive(1'b0, 1'b0, 3'd0, 32'd0, 1'b1, addr, acc, pm);
  endtask

  // user read, user write, machine exec
  task automatic probe(input logic [31:0] addr);
    check(addr, pmp_pkg::READ, 1'b0);
    check(addr, pmp_pkg::WRITE, 1'b0);
    check(addr, pmp_pkg::EXEC, 1'b1);
  endtask

  // drain results then switch test and reset to clear locks
  task automatic start_test(input logic [3:0] n);
    idle();
    idle();
    @(posedge clk);
    test_id <= n;
    rst     <= (n != 4'd0);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  initial begin
    rst         = 1'b1;
    csr_we      = 1'b0;
    csr_sel_cfg = 1'b0;
    csr_index   = 3'd0;
    csr_wdata   = 32'd0;
    chk_valid   = 1'b0;
    chk_addr    = 32'd0;
    chk_access  = pmp_pkg::READ;
    chk_priv_m  = 1'b0;
    test_id     = 4'd0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // test 1 checks TOR bounds and the empty ranges of entries 2 and 3
    start_test(4'd1);
    write_addr(3'd0, 32'h100);
    write_addr(3'd1, 32'h200);
    write_addr(3'd2, 32'h200);      // equal bounds
    write_addr(3'd3, 32'h150);      // inverted bounds
    write_cfg(3'd0, cfg_word(
        cfg_byte(1'b0, pmp_pkg::TOR, 3'b111), cfg_byte(1'b0, pmp_pkg::TOR, 3'b111),
        cfg_byte(1'b0, pmp_pkg::TOR, 3'b001), cfg_byte(1'b0, pmp_pkg::OFF, 3'b000)));
    foreach (tor_pts[i]) probe(tor_pts[i]);

    // test 2 covers NA4 and NAPOT sizes with the all-ones cases last
    start_test(4'd2);
    write_addr(3'd4, 32'h300);
    write_addr(3'd5, 32'h401);      // 4 words at 0x400
    write_addr(3'd6, 32'h8ff);      // 512 words at 0x800
    write_addr(3'd7, 32'h7fff_ffff);
    write_cfg(3'd1, cfg_word(
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b001), cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b111),
        cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b011), cfg_byte(1'b0, pmp_pkg::NA4, 3'b101)));
    probe(32'h2ff);
    probe(32'h300);
    probe(32'h301);
    repeat (12) begin
      probe(32'h400 | lfsr_take(2));
      probe(32'h800 | lfsr_take(9));
      probe(lfsr_take(12));
    end
    write_cfg(3'd1, cfg_word(
        cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b001), cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b111),
        cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b011), cfg_byte(1'b0, pmp_pkg::NA4, 3'b101)));
    repeat (4) probe(lfsr_take(32));
    write_addr(3'd7, 32'hffff_ffff);
    repeat (4) probe(lfsr_take(32));

    // test 3 overlaps NAPOT regions with read only entry 0 inside entry 1
    start_test(4'd3);
    write_addr(3'd0, 32'h1007);
    write_addr(3'd1, 32'h101f);
    write_cfg(3'd0, cfg_word(
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b000), cfg_byte(1'b0, pmp_pkg::OFF, 3'b000),
        cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b111), cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b001)));
    probe(32'h1004);
    probe(32'h1020);
    probe(32'h1040);
    probe(32'h0fff);

    // test 4 covers no hit and then unlocked vs locked entries in machine mode
    start_test(4'd4);
    check(32'h55, pmp_pkg::READ, 1'b1);
    check(32'h55, pmp_pkg::READ, 1'b0);
    check(32'h55, pmp_pkg::EXEC, 1'b1);
    check(32'h55, pmp_pkg::EXEC, 1'b0);
    write_addr(3'd0, 32'h20);
    write_addr(3'd1, 32'h30);
    write_cfg(3'd0, cfg_word(
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b000), cfg_byte(1'b0, pmp_pkg::OFF, 3'b000),
        cfg_byte(1'b1, pmp_pkg::NA4, 3'b000), cfg_byte(1'b0, pmp_pkg::NA4, 3'b000)));
    check(32'h20, pmp_pkg::WRITE, 1'b1);
    check(32'h20, pmp_pkg::WRITE, 1'b0);
    check(32'h30, pmp_pkg::WRITE, 1'b1);
    check(32'h30, pmp_pkg::READ, 1'b0);

    // test 5 has a locked byte and address that hold while the neighbour byte updates
    start_test(4'd5);
    write_addr(3'd0, 32'h10);
    write_cfg(3'd0, cfg_word(
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b000), cfg_byte(1'b0, pmp_pkg::OFF, 3'b000),
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b000), cfg_byte(1'b1, pmp_pkg::NA4, 3'b001)));
    write_cfg(3'd0, cfg_word(
        cfg_byte(1'b0, pmp_pkg::OFF, 3'b000), cfg_byte(1'b0, pmp_pkg::OFF, 3'b000),
        cfg_byte(1'b0, pmp_pkg::NA4, 3'b011), cfg_byte(1'b0, pmp_pkg::NAPOT, 3'b111)));
    write_addr(3'd0, 32'h99);
    write_addr(3'd1, 32'h40);
    probe(32'h10);
    probe(32'h99);
    probe(32'h40);

    // test 6 runs random writes and checks back to back
    start_test(4'd6);
    repeat (NUM_RANDOM) begin
      r_we   = lfsr_take(2);
      r_sel  = lfsr_take(1);
      r_idx  = lfsr_take(3);
      r_data = r_sel[0] ? lfsr_take(32) : lfsr_take(10); // small addresses so ranges get hit
      r_acc  = lfsr_take(2);
      r_addr = lfsr_take(10);
      r_pm   = lfsr_take(1);
      drive(r_we[1:0] == 2'd0, r_sel[0], r_idx[2:0], r_data, 1'b1, r_addr,
            (r_acc[1:0] == 2'd3) ? pmp_pkg::READ : pmp_pkg::pmp_access_e'(r_acc[1:0]), r_pm[0]);
    end

    start_test(4'd0); // closes the last test
    wait (summary_done);
    if (err_total == 0 && pmp_checker_i.asserts_i.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // run limit from the test lengths above
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verif/pmp_result_check.sv
// ----------------------------------------------------------
// shadow CSR copy with lock rule, reference result, compare
// sampled on the falling edge, result due one cycle after check
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "pmp_settings.svh"

module pmp_result_check (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 csr_we,
  input  logic                 csr_sel_cfg,
  input  logic [2:0]           csr_index,
  input  logic [31:0]          csr_wdata,
  input  logic                 chk_valid,
  input  logic [31:0]          chk_addr,
  input  pmp_pkg::pmp_access_e chk_access,
  input  logic                 chk_priv_m,
  input  logic                 res_valid,
  input  logic                 res_fault,
  input  logic [2:0]           res_entry,
  input  logic                 res_hit,
  input  logic [3:0]           test_id,     // 0 closes the run
  output int                   err_total,
  output logic                 summary_done
);

  pmp_pkg::pmp_cfg_t sh_cfg  [`PMP_ENTRIES];
  logic [31:0]       sh_addr [`PMP_ENTRIES];
  pmp_pkg::pmp_cfg_word_u wr_word;
  logic       pend = 1'b0;       // result due this cycle
  logic [4:0] exp_q;             // fault, hit, entry
  logic [3:0] cur_test = 4'd0;
  int n_chk = 0, n_err = 0, tot_chk = 0, tot_err = 0;
  logic done_q = 1'b0;

  assign err_total    = tot_err;
  assign summary_done = done_q;

  // trailing ones k -> region of 2^(k+1) words
  function automatic logic napot_hit(input logic [31:0] pa, input logic [31:0] reg_addr);
    int          ones;
    logic [31:0] mask;
    ones = 0;
    for (int i = 0; i < 32; i++) if (reg_addr[i] && ones == i) ones = i + 1;
    if (ones >= 31) return 1'b1;                          // whole space
    if (`PMP_GRAIN > 0 && ones < `PMP_GRAIN - 1) return 1'b0; // below granularity
    mask = ~((32'h2 << ones) - 32'h1);
    return (pa & mask) == (reg_addr & mask);
  endfunction

  function automatic logic entry_hit(input int e, input logic [31:0] pa);
    logic [31:0] lo;
    lo = 32'd0;
    if (e > 0) lo = sh_addr[e-1];
    case (sh_cfg[e].a)
      pmp_pkg::TOR:   return pa >= lo && pa < sh_addr[e];
      pmp_pkg::NA4:   return pa == sh_addr[e];
      pmp_pkg::NAPOT: return napot_hit(pa, sh_addr[e]);
      default:        return 1'b0;
    endcase
  endfunction

  function automatic logic [4:0] ref_result(input logic [31:0] pa,
                                            input pmp_pkg::pmp_access_e acc, input logic pm);
    logic              hit;
    logic [2:0]        idx;
    logic              allow;
    pmp_pkg::pmp_cfg_t c;
    hit = 1'b0;
    idx = 3'd0;
    c   = '0;
    for (int e = 0; e < `PMP_ENTRIES; e++) begin
      if (!hit && entry_hit(e, pa)) begin // first match wins
        hit = 1'b1;
        idx = 3'(e);
        c   = sh_cfg[e];
      end
    end
    if (!hit) allow = pm;
    else if (pm && !c.l) allow = 1'b1;
    else if (acc == pmp_pkg::READ) allow = c.r;
    else if (acc == pmp_pkg::WRITE) allow = c.w;
    else allow = (acc == pmp_pkg::EXEC) && c.x;
    return {!allow, hit, idx};
  endfunction

  task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] got);
    if (expv !== got) begin
      $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, expv, got);
      n_err++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst && pend) begin
      n_chk++;
      compare("res_valid", 32'd1, {31'd0, res_valid});
      compare("res_fault", {31'd0, exp_q[4]}, {31'd0, res_fault});
      compare("res_hit", {31'd0, exp_q[3]}, {31'd0, res_hit});
      compare("res_entry", {29'd0, exp_q[2:0]}, {29'd0, res_entry});
    end else if (!rst && res_valid) begin
      $display("error at t=%0t: res_valid high with no check issued a cycle before", $time);
      n_err++;
    end
    if (test_id != cur_test) begin
      if (cur_test != 4'd0) begin
        $display("test %0d done: %0d checks, %0d errors", cur_test, n_chk, n_err);
      end
      tot_chk  += n_chk;
      tot_err  += n_err;
      n_chk    = 0;
      n_err    = 0;
      cur_test = test_id;
      if (test_id == 4'd0) begin
        $display("totals: %0d checks, %0d errors", tot_chk, tot_err);
        done_q = 1'b1;
      end
    end
    if (rst) begin
      for (int e = 0; e < `PMP_ENTRIES; e++) begin
        sh_cfg[e]  = '0;
        sh_addr[e] = '0;
      end
      pend = 1'b0;
    end else begin
      pend = chk_valid;
      if (chk_valid) exp_q = ref_result(chk_addr, chk_access, chk_priv_m); // state before write
      wr_word.raw = csr_wdata;
      if (csr_we && csr_sel_cfg) begin
        for (int b = 0; b < 4; b++) begin
          if (int'(csr_index) * 4 + b < `PMP_ENTRIES && !sh_cfg[int'(csr_index) * 4 + b].l)
            sh_cfg[int'(csr_index) * 4 + b] = wr_word.bytes[b];
        end
      end else if (csr_we && !sh_cfg[csr_index].l) begin
        sh_addr[csr_index] = csr_wdata;
      end
    end
  end

endmodule
